//--- hdl/spectrum_bus_pkg.sv
`default_nettype none

// ==================================================
// Bus side definitions
// ==================================================
package spectrum_bus_pkg;

  // Port opcode carried with each request
  typedef enum logic {
    BUS_READ  = 1'b0,
    BUS_WRITE = 1'b1
  } bus_op_e;

  // Request presented by the bus master
  // Held stable from req rise until ack rise
  typedef struct packed {
    bus_op_e     op;
    logic [15:0] addr;
    logic [7:0]  wdata;
  } port_req_t;

  // Response, valid while ack is high
  typedef struct packed {
    logic [7:0] rdata;
  } port_rsp_t;

  // Four-phase slave states
  // PORT_ACK holds until the master drops req
  typedef enum logic {
    PORT_IDLE = 1'b0,
    PORT_ACK  = 1'b1
  } port_state_e;

  // Border colour, GRB order as on the Spectrum
  typedef logic [2:0] border_t;

endpackage

`default_nettype wire

//--- hdl/spectrum_kbd_pkg.sv
`default_nettype none

// ==================================================
// Keyboard matrix definitions
// ==================================================
package spectrum_kbd_pkg;

  // Spectrum matrix is fixed
  // Eight half-rows, each selected by one of A8..A15
  localparam int KEY_ROWS = 8;

  // Five keys per half-row, read on D0..D4
  localparam int KEY_COLS = 5;

  // Index widths for row and column
  localparam int KEY_ROW_W = 3;
  localparam int KEY_COL_W = 3;

  // Decoded PS/2 event
  // valid is a single-cycle strobe
  // pressed low means a break code was seen
  typedef struct packed {
    logic       valid;
    logic       pressed;
    logic [7:0] scan;
  } key_event_t;

  // Update broadcast to every half-row
  // row_sel is one-hot, all zero when nothing to do
  typedef struct packed {
    logic [KEY_ROWS-1:0]  row_sel;
    logic [KEY_COL_W-1:0] col;
    logic                 pressed;
  } row_update_t;

  // Column bits of one half-row
  // Active low, 0 means the key is down
  typedef logic [KEY_COLS-1:0] key_cols_t;

  // Bit 0 is the key nearest the outer edge
  // of the physical keyboard
  // e.g. row 0 col 0 is caps shift
  // row 7 col 0 is space

endpackage

`default_nettype wire

//--- hdl/ula_bus_port.sv
`default_nettype none

module ula_bus_port (
  input  wire                                cpuClock,
  input  wire                                pwr_up_reset_n,
  // Four-phase handshake
  input  wire                                req,
  input  wire spectrum_bus_pkg::port_req_t   req_data,
  output logic                               ack,
  output spectrum_bus_pkg::port_rsp_t        rsp,
  // Keyboard matrix access
  output logic [7:0]                         sel_row,
  input  wire spectrum_kbd_pkg::key_cols_t   cols,
  // ULA outputs
  output spectrum_bus_pkg::border_t          border,
  output logic                               sound
);

  import spectrum_bus_pkg::*;

  port_state_e state;
  logic        accept;
  logic        even_port;
  logic [7:0]  rdata_next;

  // ==================================================
  // Port decode
  // ==================================================

  // ULA answers on every even port
  assign even_port = ~req_data.addr[0];

  // High address byte picks the half-rows
  assign sel_row = req_data.addr[15:8];

  // Upper three bits float high
  // Odd ports are not ours
  always_comb begin
    if (even_port) begin
      rdata_next = {3'b111, cols};
    end else begin
      rdata_next = 8'hff;
    end
  end

  // ==================================================
  // Handshake FSM
  // ==================================================

  // New request taken only from idle
  assign accept = (state == PORT_IDLE) && req;

  assign ack = (state == PORT_ACK);

  always_ff @(posedge cpuClock) begin
    if (!pwr_up_reset_n) begin
      state <= PORT_IDLE;
    end else begin
      case (state)
        PORT_IDLE: begin
          if (req) begin
            state <= PORT_ACK;
          end
        end
        PORT_ACK: begin
          // Wait for master to release
          if (!req) begin
            state <= PORT_IDLE;
          end
        end
        default: state <= PORT_IDLE;
      endcase
    end
  end

  // Read data captured on accept, held through ack
  always_ff @(posedge cpuClock) begin
    if (accept) begin
      rsp.rdata <= rdata_next;
    end
  end

  // Border and speaker latch
  // Bit 3 is MIC, not modelled
  always_ff @(posedge cpuClock) begin
    if (!pwr_up_reset_n) begin
      border <= '0;
      sound  <= 1'b0;
    end else if (accept && req_data.op == BUS_WRITE && even_port) begin
      border <= req_data.wdata[2:0];
      sound  <= req_data.wdata[4];
    end
  end

  // ==================================================
  // Checks
  // ==================================================

  // Ack only ever answers a request
  a_ack_needs_req: assert property (@(posedge cpuClock) disable iff (!pwr_up_reset_n)
    $rose(ack) |-> $past(req));

endmodule

`default_nettype wire

//--- hdl/key_mapper.sv
`default_nettype none

module key_mapper (
  input  wire                                 cpuClock,
  input  wire                                 pwr_up_reset_n,
  input  wire spectrum_kbd_pkg::key_event_t   key_in,
  output spectrum_kbd_pkg::row_update_t       row_update
);

  import spectrum_kbd_pkg::*;

  // Matrix position of one scan code
  typedef struct packed {
    logic                 hit;
    logic [KEY_ROW_W-1:0] row;
    logic [KEY_COL_W-1:0] col;
  } key_pos_t;

  key_pos_t             pos;
  logic [KEY_ROWS-1:0]  sel_q;
  logic [KEY_COL_W-1:0] col_q;
  logic                 pressed_q;

  // ==================================================
  // Set-2 scan code table
  // ==================================================
  always_comb begin
    case (key_in.scan)
      // Row 0, caps shift Z X C V
      8'h12: pos = '{1'b1, 3'd0, 3'd0};
      8'h1a: pos = '{1'b1, 3'd0, 3'd1};
      8'h22: pos = '{1'b1, 3'd0, 3'd2};
      8'h21: pos = '{1'b1, 3'd0, 3'd3};
      8'h2a: pos = '{1'b1, 3'd0, 3'd4};
      // Row 1, A S D F G
      8'h1c: pos = '{1'b1, 3'd1, 3'd0};
      8'h1b: pos = '{1'b1, 3'd1, 3'd1};
      8'h23: pos = '{1'b1, 3'd1, 3'd2};
      8'h2b: pos = '{1'b1, 3'd1, 3'd3};
      8'h34: pos = '{1'b1, 3'd1, 3'd4};
      // Row 2, Q W E R T
      8'h15: pos = '{1'b1, 3'd2, 3'd0};
      8'h1d: pos = '{1'b1, 3'd2, 3'd1};
      8'h24: pos = '{1'b1, 3'd2, 3'd2};
      8'h2d: pos = '{1'b1, 3'd2, 3'd3};
      8'h2c: pos = '{1'b1, 3'd2, 3'd4};
      // Row 3, 1 to 5
      8'h16: pos = '{1'b1, 3'd3, 3'd0};
      8'h1e: pos = '{1'b1, 3'd3, 3'd1};
      8'h26: pos = '{1'b1, 3'd3, 3'd2};
      8'h25: pos = '{1'b1, 3'd3, 3'd3};
      8'h2e: pos = '{1'b1, 3'd3, 3'd4};
      // Row 4, 0 down to 6
      8'h45: pos = '{1'b1, 3'd4, 3'd0};
      8'h46: pos = '{1'b1, 3'd4, 3'd1};
      8'h3e: pos = '{1'b1, 3'd4, 3'd2};
      8'h3d: pos = '{1'b1, 3'd4, 3'd3};
      8'h36: pos = '{1'b1, 3'd4, 3'd4};
      // Row 5, P O I U Y
      8'h4d: pos = '{1'b1, 3'd5, 3'd0};
      8'h44: pos = '{1'b1, 3'd5, 3'd1};
      8'h43: pos = '{1'b1, 3'd5, 3'd2};
      8'h3c: pos = '{1'b1, 3'd5, 3'd3};
      8'h35: pos = '{1'b1, 3'd5, 3'd4};
      // Row 6, enter L K J H
      8'h5a: pos = '{1'b1, 3'd6, 3'd0};
      8'h4b: pos = '{1'b1, 3'd6, 3'd1};
      8'h42: pos = '{1'b1, 3'd6, 3'd2};
      8'h3b: pos = '{1'b1, 3'd6, 3'd3};
      8'h33: pos = '{1'b1, 3'd6, 3'd4};
      // Row 7, space, symbol shift on right shift, M N B
      8'h29: pos = '{1'b1, 3'd7, 3'd0};
      8'h59: pos = '{1'b1, 3'd7, 3'd1};
      8'h3a: pos = '{1'b1, 3'd7, 3'd2};
      8'h31: pos = '{1'b1, 3'd7, 3'd3};
      8'h32: pos = '{1'b1, 3'd7, 3'd4};
      // Anything else is dropped
      default: pos = '0;
    endcase
  end

  // ==================================================
  // Registered update
  // ==================================================

  // One-hot row select, cleared when idle
  always_ff @(posedge cpuClock) begin
    if (!pwr_up_reset_n) begin
      sel_q <= '0;
    end else if (key_in.valid && pos.hit) begin
      sel_q <= KEY_ROWS'(1) << pos.row;
    end else begin
      sel_q <= '0;
    end
  end

  // Column and make/break travel alongside
  always_ff @(posedge cpuClock) begin
    col_q     <= pos.col;
    pressed_q <= key_in.pressed;
  end

  assign row_update = '{row_sel: sel_q, col: col_q, pressed: pressed_q};

endmodule

`default_nettype wire

//--- hdl/key_row.sv
`default_nettype none

module key_row #(
  parameter int unsigned ROW_INDEX = 0
) (
  input  wire                                  cpuClock,
  input  wire                                  pwr_up_reset_n,
  input  wire spectrum_kbd_pkg::row_update_t   row_update,
  output spectrum_kbd_pkg::key_cols_t          cols
);

  import spectrum_kbd_pkg::*;

  // This half-row addressed by the mapper
  logic hit;

  assign hit = row_update.row_sel[ROW_INDEX];

  // Key state, all released out of reset
  always_ff @(posedge cpuClock) begin
    if (!pwr_up_reset_n) begin
      cols <= '1;
    end else if (hit) begin
      for (int i = 0; i < KEY_COLS; i++) begin
        // Pressed pulls the line low
        if (row_update.col == KEY_COL_W'(i)) begin
          cols[i] <= ~row_update.pressed;
        end
      end
    end
  end

  // Mapper never names a column past the fifth key
  a_col_in_range: assert property (@(posedge cpuClock) disable iff (!pwr_up_reset_n)
    hit |-> (row_update.col < KEY_COL_W'(KEY_COLS)));

endmodule

`default_nettype wire

//--- hdl/row_merge.sv
`default_nettype none

module row_merge (
  input  wire spectrum_kbd_pkg::key_cols_t [spectrum_kbd_pkg::KEY_ROWS-1:0] rows,
  input  wire [spectrum_kbd_pkg::KEY_ROWS-1:0]                              sel_row,
  output spectrum_kbd_pkg::key_cols_t                                       cols
);

  import spectrum_kbd_pkg::*;

  key_cols_t merged;

  // ==================================================
  // Column merge
  // ==================================================

  // Address line low selects a half-row
  // Several rows read together AND their columns
  // No row selected reads as nothing pressed
  // Plain AND only, so no ghost keys appear
  always_comb begin
    merged = '1;
    for (int r = 0; r < KEY_ROWS; r++) begin
      if (!sel_row[r]) begin
        merged = merged & rows[r];
      end
    end
  end

  assign cols = merged;

endmodule

`default_nettype wire

//--- hdl/ula_io.sv
`default_nettype none

module ula_io (
  input  wire                                cpuClock,
  input  wire                                pwr_up_reset_n,
  // Port bus
  input  wire                                req,
  input  wire spectrum_bus_pkg::port_req_t   req_data,
  output wire                                ack,
  output spectrum_bus_pkg::port_rsp_t        rsp,
  // Decoded PS/2 events
  input  wire spectrum_kbd_pkg::key_event_t  key_in,
  // ULA outputs
  output spectrum_bus_pkg::border_t          border,
  output wire                                sound
);

  import spectrum_kbd_pkg::*;

  logic [7:0]                 sel_row;
  key_cols_t                  merged_cols;
  key_cols_t [KEY_ROWS-1:0]   row_cols;
  row_update_t                row_update;

  // ==================================================
  // Port side
  // ==================================================
  ula_bus_port u_port (
    .cpuClock       (cpuClock),
    .pwr_up_reset_n (pwr_up_reset_n),
    .req            (req),
    .req_data       (req_data),
    .ack            (ack),
    .rsp            (rsp),
    .sel_row        (sel_row),
    .cols           (merged_cols),
    .border         (border),
    .sound          (sound)
  );

  // ==================================================
  // Keyboard matrix
  // ==================================================
  key_mapper u_mapper (
    .cpuClock       (cpuClock),
    .pwr_up_reset_n (pwr_up_reset_n),
    .key_in         (key_in),
    .row_update     (row_update)
  );

  // One half-row per address line
  for (genvar gi = 0; gi < KEY_ROWS; gi++) begin : g_row
    key_row #(
      .ROW_INDEX (gi)
    ) u_row (
      .cpuClock       (cpuClock),
      .pwr_up_reset_n (pwr_up_reset_n),
      .row_update     (row_update),
      .cols           (row_cols[gi])
    );
  end

  row_merge u_merge (
    .rows    (row_cols),
    .sel_row (sel_row),
    .cols    (merged_cols)
  );

endmodule

`default_nettype wire

//--- verification/ula_io_tb.sv
`default_nettype none

module ula_io_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import spectrum_bus_pkg::*;
  import spectrum_kbd_pkg::*;

  // Set-2 codes, five per half-row, column 0 first
  localparam logic [7:0] scan_table [40] = '{
    8'h12, 8'h1a, 8'h22, 8'h21, 8'h2a, 8'h1c, 8'h1b, 8'h23, 8'h2b, 8'h34,
    8'h15, 8'h1d, 8'h24, 8'h2d, 8'h2c, 8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e,
    8'h45, 8'h46, 8'h3e, 8'h3d, 8'h36, 8'h4d, 8'h44, 8'h43, 8'h3c, 8'h35,
    8'h5a, 8'h4b, 8'h42, 8'h3b, 8'h33, 8'h29, 8'h59, 8'h3a, 8'h31, 8'h32
  };
  localparam int wait_limit = 16;

  logic       cpuClock;
  logic       pwr_up_reset_n;
  logic       req;
  port_req_t  req_data;
  logic       ack;
  port_rsp_t  rsp;
  key_event_t key_in;
  border_t    border;
  logic       sound;

  // Reference model, keys active low
  key_cols_t   key_m [KEY_ROWS];
  border_t     border_m;
  logic        sound_m;
  logic [31:0] seed;
  int          errors;
  int          timeouts;

  ula_io dut (
    .cpuClock       (cpuClock),
    .pwr_up_reset_n (pwr_up_reset_n),
    .req            (req),
    .req_data       (req_data),
    .ack            (ack),
    .rsp            (rsp),
    .key_in         (key_in),
    .border         (border),
    .sound          (sound)
  );

  initial begin
    cpuClock = 1'b0;
    forever #10 cpuClock = ~cpuClock;
  end

  // ==================================================
  // Helpers
  // ==================================================
  task automatic flag_error(input string msg);
    errors++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timed out at %0t waiting for %s", $time, what);
  endtask

  // Plain LCG, full 32-bit state
  function automatic logic [31:0] rand_word();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Table index of a scan code, -1 if unknown
  function automatic int find_key(input logic [7:0] scan);
    for (int i = 0; i < 40; i++) begin
      if (scan_table[i] == scan) begin
        return i;
      end
    end
    return -1;
  endfunction

  // Even port: three high bits over the AND of selected rows
  function automatic logic [7:0] expected_read(input logic [15:0] addr);
    key_cols_t c;
    c = '1;
    if (addr[0]) begin
      return 8'hff;
    end
    for (int r = 0; r < KEY_ROWS; r++) begin
      if (!addr[8+r]) begin
        c = c & key_m[r];
      end
    end
    return {3'b111, c};
  endfunction

  // One full four-phase transfer
  // Master keeps req up one to four cycles past ack
  task automatic port_access(input bus_op_e op, input logic [15:0] addr,
                             input logic [7:0] wdata);
    int         n;
    int         hold;
    logic [7:0] expected;
    expected = expected_read(addr);
    hold = 1 + int'(rand_word() >> 30);
    req_data = '{op: op, addr: addr, wdata: wdata};
    req = 1'b1;
    n = 0;
    while (!ack && n < wait_limit) begin
      @(posedge cpuClock);
      #2;
      n++;
    end
    if (!ack) begin
      report_timeout("ack to rise");
    end else begin
      // Border and speaker take effect with ack
      if (op == BUS_WRITE && !addr[0]) begin
        border_m = wdata[2:0];
        sound_m  = wdata[4];
      end
      if (op == BUS_READ) begin
        assert (rsp.rdata == expected) else
          flag_error($sformatf("read of port %h gave %h, expected %h",
                               addr, rsp.rdata, expected));
      end
      repeat (hold) begin
        @(posedge cpuClock);
        #2;
      end
    end
    req = 1'b0;
    n = 0;
    while (ack && n < wait_limit) begin
      @(posedge cpuClock);
      #2;
      n++;
    end
    if (ack) begin
      report_timeout("ack to fall after req dropped");
    end
  endtask

  // Strobe one key event, then let mapper and row register settle
  task automatic key_event(input logic [7:0] scan, input logic pressed);
    int idx;
    key_in = '{valid: 1'b1, pressed: pressed, scan: scan};
    @(posedge cpuClock);
    #2;
    key_in.valid = 1'b0;
    repeat (2) @(posedge cpuClock);
    #2;
    idx = find_key(scan);
    if (idx >= 0) begin
      key_m[idx / 5][idx % 5] = ~pressed;
    end
  endtask

  // ==================================================
  // Handshake and output checks
  // ==================================================
  a_ack_after_req: assert property (@(posedge cpuClock) disable iff (!pwr_up_reset_n)
    $rose(ack) |-> $past(req)) else flag_error("ack rose without req");
  a_no_spurious_ack: assert property (@(posedge cpuClock) disable iff (!pwr_up_reset_n)
    !req && !ack |=> !ack) else flag_error("ack rose while idle");
  a_ack_holds: assert property (@(posedge cpuClock) disable iff (!pwr_up_reset_n)
    ack && req |=> ack) else flag_error("ack dropped while req high");
  a_ack_drops: assert property (@(posedge cpuClock) disable iff (!pwr_up_reset_n)
    ack && !req |=> !ack) else flag_error("ack late after req fell");
  a_rsp_stable: assert property (@(posedge cpuClock) disable iff (!pwr_up_reset_n)
    ack && $past(ack) |-> $stable(rsp)) else flag_error("rsp moved during ack");
  a_outputs: assert property (@(posedge cpuClock) disable iff (!pwr_up_reset_n)
    border == border_m && sound == sound_m) else flag_error("border or sound mismatch");

  // ==================================================
  // Stimulus
  // ==================================================
  initial begin : main
    logic [31:0] w;
    int          k;
    int          row;
    int          picks [4];
    seed = 32'hca3;
    errors = 0;
    timeouts = 0;
    req = 1'b0;
    req_data = '0;
    key_in = '0;
    pwr_up_reset_n = 1'b0;
    border_m = '0;
    sound_m = 1'b0;
    for (int r = 0; r < KEY_ROWS; r++) begin
      key_m[r] = '1;
    end
    repeat (5) @(posedge cpuClock);
    #2 pwr_up_reset_n = 1'b1;
    assert (!ack && border == '0 && !sound) else flag_error("outputs not cleared by reset");
    port_access(BUS_READ, 16'h00fe, 8'h00);
    // Writes alternate even and odd ports
    for (int i = 0; i < 12; i++) begin
      w = rand_word();
      port_access(BUS_WRITE, {w[23:9], i[0]}, w[31:24]);
    end
    // Single key, own row, neighbour row, then release
    for (int i = 0; i < 8; i++) begin
      w = rand_word();
      k = int'(w[15:8]) % 40;
      row = k / 5;
      key_event(scan_table[k], 1'b1);
      port_access(BUS_READ, {~(8'd1 << row), w[23:17], 1'b0}, 8'h00);
      port_access(BUS_READ, {~(8'd1 << ((row + 1) % 8)), w[23:17], 1'b0}, 8'h00);
      key_event(scan_table[k], 1'b0);
      port_access(BUS_READ, {~(8'd1 << row), w[23:17], 1'b0}, 8'h00);
    end
    // Keys in several rows, multi-row reads
    for (int i = 0; i < 4; i++) begin
      w = rand_word();
      picks[i] = int'(w[19:12]) % 40;
      key_event(scan_table[picks[i]], 1'b1);
    end
    repeat (6) begin
      w = rand_word();
      port_access(BUS_READ, {w[15:8], w[23:17], 1'b0}, 8'h00);
    end
    // Esc, tab and backspace are not on the matrix
    key_event(8'h76, 1'b1);
    key_event(8'h0d, 1'b1);
    key_event(8'h66, 1'b0);
    port_access(BUS_READ, 16'h00fe, 8'h00);
    // Odd ports never see the keys
    repeat (6) begin
      w = rand_word();
      port_access(BUS_READ, {w[31:17], 1'b1}, 8'h00);
    end
    for (int i = 0; i < 4; i++) begin
      key_event(scan_table[picks[i]], 1'b0);
    end
    port_access(BUS_READ, 16'h00fe, 8'h00);
    repeat (2) @(posedge cpuClock);
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ula_io.f
hdl/spectrum_bus_pkg.sv
hdl/spectrum_kbd_pkg.sv
hdl/ula_bus_port.sv
hdl/key_mapper.sv
hdl/key_row.sv
hdl/row_merge.sv
hdl/ula_io.sv
verification/ula_io_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the ula_io testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f ula_io.f --top-module ula_io_tb -o ula_io_sim

./obj_dir/ula_io_sim | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
